/* csrMapPkg.sv */
`default_nettype none

package csrMapPkg;

	// Word offsets inside the block, taken from address bits 7 to 0
	typedef enum logic [7:0]
	{
		// Device configuration controls
		CFG_CMD   = 8'h00,
		CFG_EN    = 8'h01,
		CFG_RST   = 8'h02,

		// Memory access tester controls
		MAT_EN    = 8'h10,
		MAT_RST   = 8'h11,
		MAT_WD    = 8'h12,
		MAT_WD_OE = 8'h13,
		MAT_WA    = 8'h14,
		MAT_WE    = 8'h15,
		MAT_RA    = 8'h16,

		// Read-only status
		CFG_DONE  = 8'h40,
		MAT_DONE  = 8'h50,
		MAT_RD    = 8'h51
	} csrAddrE;

endpackage

`default_nettype wire

/* list.f */
+incdir+.
csrMapPkg.sv
ramCtrlPkg.sv
ramArray.sv
ramCsr.sv
ramDeviceInit.sv
memAccessTester.sv
ramSubsystem.sv
tbClock.sv
tbRamSubsystem.sv

/* memAccessTester.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ram_defines.svh"

module memAccessTester import ramCtrlPkg::*;
(
	input  wire                         iSCLK,
	input  wire                         iSRST,
	input  wire                         matEn,
	input  wire                         matRst,
	input  wire [`RAM_DQ_WIDTH-1:0]     matMemWd,
	input  wire                         matMemWdOe,
	input  wire [`RAM_ADRS_WIDTH-1:0]   matMemWa,
	input  wire                         matMemWe,
	input  wire [`RAM_ADRS_WIDTH-1:0]   matMemRa,
	input  wire [`RAM_DQ_WIDTH-1:0]     ramRd,
	output logic                        matDone,
	output logic [`RAM_DQ_WIDTH-1:0]    matMemRd,
	output logic                        ramWe,
	output logic [`RAM_ADRS_WIDTH-1:0]  ramWa,
	output logic [`RAM_DQ_WIDTH-1:0]    ramWd,
	output logic [`RAM_ADRS_WIDTH-1:0]  ramRa
);

	matStateE state;
	logic     matEnDly;
	logic     startEdge;

	assign startEdge = matEn && !matEnDly;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			matEnDly <= 1'b0;
		else
			matEnDly <= matEn;
	end

	// --------------------
	// Control FSM
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST || matRst)
		begin
			state    <= TST_IDLE;
			matDone  <= 1'b0;
			matMemRd <= '0;
			ramWe    <= 1'b0;
		end
		else
		begin
			case (state)
				TST_IDLE:
				begin
					if (startEdge)
					begin
						state <= TST_WRITE;
						ramWe <= matMemWe;
					end
				end
				TST_WRITE:
				begin
					// Strobe lasts this one cycle
					ramWe <= 1'b0;
					state <= TST_READ;
				end
				TST_READ:
					state <= TST_CAPTURE;
				TST_CAPTURE:
				begin
					// Readback path
					matMemRd <= ramRd;
					matDone  <= 1'b1;
					state    <= TST_DONE;
				end
				TST_DONE:
				begin
					if (!matEn)
					begin
						state   <= TST_IDLE;
						matDone <= 1'b0;
					end
				end
				default:
					state <= TST_IDLE;
			endcase
		end
	end

	// --------------------
	// Write path
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (state == TST_IDLE && startEdge)
		begin
			ramWa <= matMemWa;
			ramWd <= matMemWdOe ? matMemWd : `RAM_UNDRIVEN;
		end
		if (state == TST_WRITE)
			ramRa <= matMemRa;
	end

endmodule

`default_nettype wire

/* ramArray.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ram_defines.svh"

module ramArray
(
	input  wire                         iSCLK,
	input  wire                         ramWe,
	input  wire [`RAM_ADRS_WIDTH-1:0]   ramWa,
	input  wire [`RAM_DQ_WIDTH-1:0]     ramWd,
	input  wire [`RAM_ADRS_WIDTH-1:0]   ramRa,
	output logic [`RAM_DQ_WIDTH-1:0]    ramRd
);

	localparam int depth = 1 << `RAM_ADRS_WIDTH;

	logic [`RAM_DQ_WIDTH-1:0] mem [depth];

	// Write port
	always_ff @(posedge iSCLK)
	begin
		if (ramWe)
			mem[ramWa] <= ramWd;
	end

	// Registered read, same address sees the old word
	always_ff @(posedge iSCLK)
	begin
		ramRd <= mem[ramRa];
	end

endmodule

`default_nettype wire

/* ramCsr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ram_defines.svh"

module ramCsr import csrMapPkg::*;
(
	input  wire                         iSCLK,
	input  wire                         iSRST,
	input  wire [`USI_BUS_WIDTH-1:0]    usiAdrs,
	input  wire [`USI_BUS_WIDTH-1:0]    usiWd,
	input  wire                         cfgDone,
	input  wire                         matDone,
	input  wire [`RAM_DQ_WIDTH-1:0]     matMemRd,
	output logic [`USI_BUS_WIDTH-1:0]   usiRd,
	output logic [`CFG_CMD_WIDTH-1:0]   cfgCmd,
	output logic                        cfgEn,
	output logic                        cfgRst,
	output logic                        matEn,
	output logic                        matRst,
	output logic [`RAM_DQ_WIDTH-1:0]    matMemWd,
	output logic                        matMemWdOe,
	output logic [`RAM_ADRS_WIDTH-1:0]  matMemWa,
	output logic                        matMemWe,
	output logic [`RAM_ADRS_WIDTH-1:0]  matMemRa
);

	localparam int busW = `USI_BUS_WIDTH;

	logic [7:0] offset;
	logic       wrHit;

	// --------------------
	// Address decode
	// --------------------
	assign offset = usiAdrs[7:0];

	// Write bit set and block field ours
	assign wrHit = usiAdrs[`CSR_WRITE_BIT]
		&& (usiAdrs[`CSR_BLOCK_MSB:`CSR_BLOCK_LSB] == `CSR_BLOCK_ID);

	// --------------------
	// Register writes
	// --------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			cfgCmd     <= `CFG_CMD_RESET;
			cfgEn      <= 1'b0;
			cfgRst     <= 1'b1;
			matEn      <= 1'b0;
			matRst     <= 1'b1;
			matMemWd   <= '0;
			matMemWdOe <= 1'b1;
			matMemWa   <= '0;
			matMemWe   <= 1'b0;
			matMemRa   <= '0;
		end
		else if (wrHit)
		begin
			// Only the addressed field moves, from the low bits of the word
			case (offset)
				CFG_CMD:
					cfgCmd <= usiWd[`CFG_CMD_WIDTH-1:0];
				CFG_EN:
					cfgEn <= usiWd[0];
				CFG_RST:
					cfgRst <= usiWd[0];
				MAT_EN:
					matEn <= usiWd[0];
				MAT_RST:
					matRst <= usiWd[0];
				MAT_WD:
					matMemWd <= usiWd[`RAM_DQ_WIDTH-1:0];
				MAT_WD_OE:
					matMemWdOe <= usiWd[0];
				MAT_WA:
					matMemWa <= usiWd[`RAM_ADRS_WIDTH-1:0];
				MAT_WE:
					matMemWe <= usiWd[0];
				MAT_RA:
					matMemRa <= usiWd[`RAM_ADRS_WIDTH-1:0];
				default:
				begin
					// Status offsets are read only
				end
			endcase
		end
	end

	// --------------------
	// Read mux
	// --------------------
	// Block field is not checked here, any block sees its offset
	always_ff @(posedge iSCLK)
	begin
		case (offset)
			CFG_CMD:
				usiRd <= busW'(cfgCmd);
			CFG_EN:
				usiRd <= busW'(cfgEn);
			CFG_RST:
				usiRd <= busW'(cfgRst);
			MAT_EN:
				usiRd <= busW'(matEn);
			MAT_RST:
				usiRd <= busW'(matRst);
			MAT_WD:
				usiRd <= busW'(matMemWd);
			MAT_WD_OE:
				usiRd <= busW'(matMemWdOe);
			MAT_WA:
				usiRd <= busW'(matMemWa);
			MAT_WE:
				usiRd <= busW'(matMemWe);
			MAT_RA:
				usiRd <= busW'(matMemRa);
			CFG_DONE:
				usiRd <= busW'(cfgDone);
			MAT_DONE:
				usiRd <= busW'(matDone);
			MAT_RD:
				usiRd <= busW'(matMemRd);
			default:
				// Unmapped offset returns the write data
				usiRd <= usiWd;
		endcase
	end

endmodule

`default_nettype wire

/* ramCtrlPkg.sv */
`default_nettype none

package ramCtrlPkg;

	// Device configuration sequencer
	typedef enum logic [1:0]
	{
		INIT_IDLE,
		INIT_SHIFT,
		INIT_DONE
	} initStateE;

	// Memory access tester, one step per state
	typedef enum logic [2:0]
	{
		TST_IDLE,
		TST_WRITE,
		TST_READ,
		TST_CAPTURE,
		TST_DONE
	} matStateE;

endpackage

`default_nettype wire

/* ramDeviceInit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ram_defines.svh"

module ramDeviceInit import ramCtrlPkg::*;
(
	input  wire                        iSCLK,
	input  wire                        iSRST,
	input  wire [`CFG_CMD_WIDTH-1:0]   cfgCmd,
	input  wire                        cfgEn,
	input  wire                        cfgRst,
	output logic                       cfgDone,
	output logic                       devCs,
	output logic                       devSck,
	output logic                       devSdo
);

	localparam int phaseW = ($clog2(`DEV_BIT_CYCLES) > 0) ? $clog2(`DEV_BIT_CYCLES) : 1;
	localparam logic [phaseW-1:0] lastPhase = phaseW'(`DEV_BIT_CYCLES - 1);
	localparam int bitW = $clog2(`CFG_CMD_WIDTH);
	localparam logic [bitW-1:0] lastBit = bitW'(`CFG_CMD_WIDTH - 1);

	initStateE                  state;
	logic [`CFG_CMD_WIDTH-1:0]  shiftReg;
	logic [phaseW-1:0]          phase;
	logic [bitW-1:0]            bitCnt;

	// Command register soft reset acts like the bus reset
	always_ff @(posedge iSCLK)
	begin
		if (iSRST || cfgRst)
		begin
			state   <= INIT_IDLE;
			cfgDone <= 1'b0;
			devCs   <= 1'b1;
			devSck  <= 1'b0;
			devSdo  <= 1'b0;
			phase   <= '0;
			bitCnt  <= '0;
		end
		else
		begin
			case (state)
				INIT_IDLE:
				begin
					if (cfgEn)
					begin
						// Select the device and put out the MSB
						state    <= INIT_SHIFT;
						devCs    <= 1'b0;
						devSdo   <= cfgCmd[`CFG_CMD_WIDTH-1];
						shiftReg <= cfgCmd << 1;
						phase    <= '0;
						bitCnt   <= '0;
					end
				end
				INIT_SHIFT:
				begin
					if (phase == lastPhase)
					begin
						// End of bit
						devSck <= 1'b0;
						phase  <= '0;
						if (bitCnt == lastBit)
						begin
							state   <= INIT_DONE;
							devCs   <= 1'b1;
							cfgDone <= 1'b1;
						end
						else
						begin
							bitCnt   <= bitCnt + 1'b1;
							devSdo   <= shiftReg[`CFG_CMD_WIDTH-1];
							shiftReg <= shiftReg << 1;
						end
					end
					else
					begin
						// Clock high in the last phase of the bit
						phase  <= phase + 1'b1;
						devSck <= (phase + 1'b1 == lastPhase);
					end
				end
				INIT_DONE:
				begin
					if (!cfgEn)
					begin
						state   <= INIT_IDLE;
						cfgDone <= 1'b0;
					end
				end
				default:
					state <= INIT_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* ramSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ram_defines.svh"

module ramSubsystem
(
	input  wire                         iSCLK,
	input  wire                         iSRST,
	input  wire [`USI_BUS_WIDTH-1:0]    usiAdrs,
	input  wire [`USI_BUS_WIDTH-1:0]    usiWd,
	output logic [`USI_BUS_WIDTH-1:0]   usiRd,
	output logic                        devCs,
	output logic                        devSck,
	output logic                        devSdo
);

	// Bank to configuration sequencer
	logic [`CFG_CMD_WIDTH-1:0]  cfgCmd;
	logic                       cfgEn;
	logic                       cfgRst;
	logic                       cfgDone;

	// Bank to tester
	logic                       matEn;
	logic                       matRst;
	logic [`RAM_DQ_WIDTH-1:0]   matMemWd;
	logic                       matMemWdOe;
	logic [`RAM_ADRS_WIDTH-1:0] matMemWa;
	logic                       matMemWe;
	logic [`RAM_ADRS_WIDTH-1:0] matMemRa;
	logic                       matDone;
	logic [`RAM_DQ_WIDTH-1:0]   matMemRd;

	// Tester to RAM
	logic                       ramWe;
	logic [`RAM_ADRS_WIDTH-1:0] ramWa;
	logic [`RAM_DQ_WIDTH-1:0]   ramWd;
	logic [`RAM_ADRS_WIDTH-1:0] ramRa;
	logic [`RAM_DQ_WIDTH-1:0]   ramRd;

	ramCsr uCsr
	(
		.iSCLK      (iSCLK),
		.iSRST      (iSRST),
		.usiAdrs    (usiAdrs),
		.usiWd      (usiWd),
		.cfgDone    (cfgDone),
		.matDone    (matDone),
		.matMemRd   (matMemRd),
		.usiRd      (usiRd),
		.cfgCmd     (cfgCmd),
		.cfgEn      (cfgEn),
		.cfgRst     (cfgRst),
		.matEn      (matEn),
		.matRst     (matRst),
		.matMemWd   (matMemWd),
		.matMemWdOe (matMemWdOe),
		.matMemWa   (matMemWa),
		.matMemWe   (matMemWe),
		.matMemRa   (matMemRa)
	);

	ramDeviceInit uDevInit
	(
		.iSCLK   (iSCLK),
		.iSRST   (iSRST),
		.cfgCmd  (cfgCmd),
		.cfgEn   (cfgEn),
		.cfgRst  (cfgRst),
		.cfgDone (cfgDone),
		.devCs   (devCs),
		.devSck  (devSck),
		.devSdo  (devSdo)
	);

	memAccessTester uTester
	(
		.iSCLK      (iSCLK),
		.iSRST      (iSRST),
		.matEn      (matEn),
		.matRst     (matRst),
		.matMemWd   (matMemWd),
		.matMemWdOe (matMemWdOe),
		.matMemWa   (matMemWa),
		.matMemWe   (matMemWe),
		.matMemRa   (matMemRa),
		.ramRd      (ramRd),
		.matDone    (matDone),
		.matMemRd   (matMemRd),
		.ramWe      (ramWe),
		.ramWa      (ramWa),
		.ramWd      (ramWd),
		.ramRa      (ramRa)
	);

	ramArray uRam
	(
		.iSCLK (iSCLK),
		.ramWe (ramWe),
		.ramWa (ramWa),
		.ramWd (ramWd),
		.ramRa (ramRa),
		.ramRd (ramRd)
	);

endmodule

`default_nettype wire

/* ram_defines.svh */
`ifndef RAM_DEFINES_SVH
`define RAM_DEFINES_SVH

// Bus and memory widths
`define USI_BUS_WIDTH   32
`define RAM_DQ_WIDTH    16
`define RAM_ADRS_WIDTH  8
`define CFG_CMD_WIDTH   8

// Register bank address decode
`define CSR_WRITE_BIT   30
`define CSR_BLOCK_MSB   15
`define CSR_BLOCK_LSB   8
`define CSR_BLOCK_ID    8'h01

// Reset value of the device command
`define CFG_CMD_RESET   8'h35

// Clocks per bit on the device serial link
`define DEV_BIT_CYCLES  2

// Word stored when the tester data driver is off
`define RAM_UNDRIVEN    16'hFFFF

`endif

/* run.sh */
#!/bin/sh
# Build and run the RAM subsystem testbench with Verilator
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
		--top-module tbRamSubsystem -o simRam \
	&& ./obj_dir/simRam | grep "RESULT: PASS" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock
#(
	parameter int halfPeriod  = 4,
	parameter int resetCycles = 16
)
(
	output logic iSCLK,
	output logic iSRST
);

	// 8 ns period
	initial
	begin
		iSCLK = 1'b0;
		forever
			#halfPeriod iSCLK = ~iSCLK;
	end

	// Reset held for the first cycles, released just after an edge
	initial
	begin
		iSRST = 1'b1;
		repeat (resetCycles) @(posedge iSCLK);
		#1;
		iSRST = 1'b0;
	end

endmodule

`default_nettype wire

/* tbRamSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ram_defines.svh"

module tbRamSubsystem import csrMapPkg::*;
();

	localparam int timeoutCycles = 50;
	localparam int numRegs = 10;

	// Writable registers with field masks and reset values
	localparam logic [7:0] regOffsets [numRegs] = '{CFG_CMD, CFG_EN, CFG_RST, MAT_EN,
		MAT_RST, MAT_WD, MAT_WD_OE, MAT_WA, MAT_WE, MAT_RA};
	localparam logic [31:0] regMasks [numRegs] = '{32'h0000_00FF, 32'h1, 32'h1, 32'h1,
		32'h1, 32'h0000_FFFF, 32'h1, 32'h0000_00FF, 32'h1, 32'h0000_00FF};
	localparam logic [31:0] regResets [numRegs] = '{32'h35, 32'h0, 32'h1, 32'h0,
		32'h1, 32'h0, 32'h1, 32'h0, 32'h0, 32'h0};

	logic        iSCLK;
	logic        iSRST;
	logic [31:0] usiAdrs;
	logic [31:0] usiWd;
	logic [31:0] usiRd;
	logic        devCs;
	logic        devSck;
	logic        devSdo;

	int errCount;
	int timeoutCount;

	// Reference model of the RAM and addresses written so far
	logic [15:0] refMem [256];
	logic [7:0]  usedAdrs [$];

	// Serial frame captured from the device pins
	int         monCount = 0;
	logic [7:0] monBits = 8'h00;

	tbClock uClock
	(
		.iSCLK (iSCLK),
		.iSRST (iSRST)
	);

	ramSubsystem DUT
	(
		.iSCLK   (iSCLK),
		.iSRST   (iSRST),
		.usiAdrs (usiAdrs),
		.usiWd   (usiWd),
		.usiRd   (usiRd),
		.devCs   (devCs),
		.devSck  (devSck),
		.devSdo  (devSdo)
	);

	// --------------------
	// Device pin monitor
	// --------------------
	// New frame on falling chip select, one bit per rising clock
	always @(negedge devCs or posedge devSck)
	begin
		if (!devSck)
		begin
			monCount = 0;
			monBits = 8'h00;
		end
		else if (!devCs)
		begin
			monBits = {monBits[6:0], devSdo};
			monCount = monCount + 1;
		end
	end

	// --------------------
	// Bus helpers
	// --------------------
	function automatic logic [31:0] makeAdrs(input logic wr, input logic [7:0] blk,
		input logic [7:0] off);
		logic [31:0] adrs;
		adrs = '0;
		adrs[`CSR_WRITE_BIT] = wr;
		adrs[`CSR_BLOCK_MSB:`CSR_BLOCK_LSB] = blk;
		adrs[7:0] = off;
		return adrs;
	endfunction

	task automatic busCycle(input logic [31:0] adrs, input logic [31:0] data);
		@(posedge iSCLK);
		#1;
		usiAdrs = adrs;
		usiWd = data;
		@(posedge iSCLK);
		#1;
		usiAdrs = '0;
	endtask

	task automatic busWrite(input logic [7:0] offset, input logic [31:0] data);
		busCycle(makeAdrs(1'b1, `CSR_BLOCK_ID, offset), data);
	endtask

	// Data shows up one clock after the address
	task automatic busRead(input logic [7:0] offset, input logic [31:0] wd,
		output logic [31:0] rd);
		@(posedge iSCLK);
		#1;
		usiAdrs = makeAdrs(1'b0, `CSR_BLOCK_ID, offset);
		usiWd = wd;
		@(posedge iSCLK);
		#1;
		rd = usiRd;
		usiAdrs = '0;
	endtask

	task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp)
		else
		begin
			errCount++;
			$display("ERR %0t: %s got %08h expected %08h", $time, what, got, exp);
		end
	endtask

	// --------------------
	// Waits
	// --------------------
	task automatic waitReset();
		int cycles;
		cycles = 0;
		// First edge sees the reset driven
		@(posedge iSCLK);
		while (iSRST && cycles < 4 * timeoutCycles)
		begin
			@(posedge iSCLK);
			cycles++;
		end
		if (iSRST)
		begin
			timeoutCount++;
			$display("Timeout at %0t: reset was never released", $time);
		end
	endtask

	task automatic waitStatus(input logic [7:0] offset, input logic [31:0] exp,
		input string what);
		logic [31:0] rd;
		int          tries;
		tries = 0;
		busRead(offset, 32'd0, rd);
		while (rd != exp && tries < timeoutCycles)
		begin
			busRead(offset, 32'd0, rd);
			tries++;
		end
		if (rd != exp)
		begin
			timeoutCount++;
			$display("Timeout at %0t: status never reached its value waiting for %s",
				$time, what);
		end
	endtask

	task automatic waitDevCs(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (devCs != level && cycles < timeoutCycles)
		begin
			@(posedge iSCLK);
			#1;
			cycles++;
		end
		if (devCs != level)
		begin
			timeoutCount++;
			$display("Timeout at %0t: chip select stuck while waiting for %s", $time, what);
		end
	endtask

	// One tester operation, left in its done state
	task automatic startAccess(input logic [7:0] wa, input logic [7:0] ra, input logic we,
		input logic oe, input logic [15:0] wd);
		busWrite(MAT_WD, 32'(wd));
		busWrite(MAT_WD_OE, 32'(oe));
		busWrite(MAT_WE, 32'(we));
		busWrite(MAT_WA, 32'(wa));
		busWrite(MAT_RA, 32'(ra));
		if (we)
			refMem[wa] = oe ? wd : 16'hFFFF;
		busWrite(MAT_EN, 32'd1);
		waitStatus(MAT_DONE, 32'd1, "memory access done");
	endtask

	task automatic endAccess();
		busWrite(MAT_EN, 32'd0);
		waitStatus(MAT_DONE, 32'd0, "memory access idle");
	endtask

	// --------------------
	// Tests
	// --------------------
	task automatic testResetValues();
		logic [31:0] rd;
		for (int i = 0; i < numRegs; i++)
		begin
			busRead(regOffsets[i], 32'd0, rd);
			checkValue($sformatf("reset value of offset %02h", regOffsets[i]), rd,
				regResets[i]);
		end
		busRead(CFG_DONE, 32'd0, rd);
		checkValue("reset CFG_DONE", rd, 32'd0);
		busRead(MAT_DONE, 32'd0, rd);
		checkValue("reset MAT_DONE", rd, 32'd0);
		busRead(MAT_RD, 32'd0, rd);
		checkValue("reset MAT_RD", rd, 32'd0);
		checkValue("reset devCs", 32'(devCs), 32'd1);
		checkValue("reset devSck", 32'(devSck), 32'd0);
	endtask

	task automatic testRegisterAccess();
		logic [7:0]  off;
		logic [31:0] value;
		logic [31:0] rd;
		for (int i = 0; i < numRegs; i++)
		begin
			off = regOffsets[i];
			value = $urandom;
			busWrite(off, value);
			busRead(off, 32'd0, rd);
			checkValue($sformatf("offset %02h readback", off), rd, value & regMasks[i]);
			// Write bit clear, then foreign block
			busCycle(makeAdrs(1'b0, `CSR_BLOCK_ID, off), ~value);
			busRead(off, 32'd0, rd);
			checkValue($sformatf("offset %02h without write bit", off), rd,
				value & regMasks[i]);
			busCycle(makeAdrs(1'b1, ~`CSR_BLOCK_ID, off), ~value);
			busRead(off, 32'd0, rd);
			checkValue($sformatf("offset %02h with wrong block", off), rd,
				value & regMasks[i]);
		end
		value = $urandom;
		busRead(8'h20, value, rd);
		checkValue("unmapped offset echo", rd, value);
		value = $urandom;
		busRead(8'hF0, value, rd);
		checkValue("unmapped offset echo", rd, value);
		// Back to a quiet state
		busWrite(CFG_RST, 32'd1);
		busWrite(MAT_RST, 32'd1);
		busWrite(CFG_EN, 32'd0);
		busWrite(MAT_EN, 32'd0);
	endtask

	task automatic testDeviceConfig();
		logic [7:0]  cmd;
		logic [31:0] rd;
		cmd = 8'($urandom);
		busWrite(CFG_CMD, 32'(cmd));
		busWrite(CFG_RST, 32'd0);
		busWrite(CFG_EN, 32'd1);
		waitStatus(CFG_DONE, 32'd1, "device configuration done");
		checkValue("serial bit count", 32'(monCount), 32'd8);
		checkValue("serial command", 32'(monBits), 32'(cmd));
		checkValue("devCs after frame", 32'(devCs), 32'd1);
		busRead(CFG_DONE, 32'd0, rd);
		checkValue("CFG_DONE held", rd, 32'd1);
		busWrite(CFG_EN, 32'd0);
		busRead(CFG_DONE, 32'd0, rd);
		checkValue("CFG_DONE after enable cleared", rd, 32'd0);
	endtask

	task automatic testMemWriteRead();
		logic [7:0]  adrs;
		logic [15:0] data;
		logic [31:0] rd;
		busWrite(MAT_RST, 32'd0);
		for (int i = 0; i < 8; i++)
		begin
			adrs = 8'($urandom);
			data = 16'($urandom);
			startAccess(adrs, adrs, 1'b1, 1'b1, data);
			busRead(MAT_RD, 32'd0, rd);
			checkValue($sformatf("MAT_RD at address %02h", adrs), rd, 32'(refMem[adrs]));
			endAccess();
			usedAdrs.push_back(adrs);
		end
	endtask

	task automatic testMemControls();
		logic [7:0]  adrs;
		logic [31:0] rd;
		adrs = 8'($urandom);
		startAccess(adrs, adrs, 1'b1, 1'b0, 16'($urandom));
		busRead(MAT_RD, 32'd0, rd);
		checkValue("MAT_RD with data driver off", rd, 32'h0000_FFFF);
		endAccess();
		// Write strobe off keeps the old word
		adrs = usedAdrs[0];
		startAccess(adrs, adrs, 1'b0, 1'b1, ~refMem[adrs]);
		busRead(MAT_RD, 32'd0, rd);
		checkValue("MAT_RD with write strobe off", rd, 32'(refMem[adrs]));
		endAccess();
		// Read address apart from the write address
		adrs = usedAdrs[1];
		startAccess(~adrs, adrs, 1'b0, 1'b1, 16'h0000);
		busRead(MAT_RD, 32'd0, rd);
		checkValue("MAT_RD from the read address", rd, 32'(refMem[adrs]));
		endAccess();
	endtask

	task automatic testSoftResets();
		logic [31:0] rd;
		startAccess(usedAdrs[0], usedAdrs[0], 1'b1, 1'b0, 16'h0000);
		busRead(MAT_RD, 32'd0, rd);
		checkValue("MAT_RD before soft reset", rd, 32'h0000_FFFF);
		busWrite(MAT_RST, 32'd1);
		busRead(MAT_DONE, 32'd0, rd);
		checkValue("MAT_DONE after soft reset", rd, 32'd0);
		busRead(MAT_RD, 32'd0, rd);
		checkValue("MAT_RD after soft reset", rd, 32'd0);
		busWrite(MAT_EN, 32'd0);
		// Abort the device frame part way
		busWrite(CFG_RST, 32'd0);
		busWrite(CFG_EN, 32'd1);
		waitDevCs(1'b0, "start of frame");
		repeat (5) @(posedge iSCLK);
		busWrite(CFG_RST, 32'd1);
		waitDevCs(1'b1, "end of aborted frame");
		busRead(CFG_DONE, 32'd0, rd);
		checkValue("CFG_DONE after abort", rd, 32'd0);
		busWrite(CFG_EN, 32'd0);
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin
		usiAdrs = '0;
		usiWd = '0;
		errCount = 0;
		timeoutCount = 0;
		void'($urandom(32'hae2a));
		waitReset();
		testResetValues();
		testRegisterAccess();
		testDeviceConfig();
		testMemWriteRead();
		testMemControls();
		testSoftResets();
		$display("Checks failed: %0d, timeouts: %0d", errCount, timeoutCount);
		if (errCount == 0 && timeoutCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Last resort if the sequence never gets to its end
	initial
	begin
		#2000000;
		$display("Watchdog expired before the tests finished");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
